// ==== verilog/icap_pkg.sv ====
// Configuration port bus slave, shared definitions
// Word constants of the port sequence, vector types,
// sequencer state encoding and the request/drive bundles

package icap_pkg;

	////////////////////
	// Slow clock divide
	////////////////////

	// Log2 of the bus-to-port clock ratio, at least 2
	localparam int LGDIV = 3;

	// Divider counts that set ready and step one cycle later
	localparam logic [LGDIV-1:0] READY_SET_CNT = LGDIV'((1 << LGDIV) - 3);
	localparam logic [LGDIV-1:0] STEP_SET_CNT  = LGDIV'((1 << LGDIV) - 2);

	////////////////////
	// Port words
	////////////////////

	localparam logic [31:0] NOOP_WORD          = 32'h2000_0000;
	localparam logic [31:0] SYNC_WORD          = 32'hAA99_5566;
	localparam logic [31:0] DUMMY_WORD         = 32'hFFFF_FFFF;
	// Type 1 write of one word to the command register
	localparam logic [31:0] CMD_REG_WRITE_WORD = 32'h3000_8001;
	localparam logic [31:0] DESYNC_CMD_WORD    = 32'h0000_000D;

	// Header opcode byte, bits 31..24
	localparam logic [7:0] RD_OPCODE = 8'h28;
	localparam logic [7:0] WR_OPCODE = 8'h30;

	typedef logic [31:0] cfg_word_t;
	typedef logic [4:0]  cfg_addr_t;

	// Reference numbering, one state per slow-clock step
	typedef enum logic [4:0] {
		IDLE, START, ACTIVATE, SYNC, SYNC_NOOP1, SYNC_NOOP2,
		RD_CMD, RD_NOOP1, RD_NOOP2, RD_IDLE,
		RD_WAIT1, RD_WAIT2, RD_WAIT3, RD_WAIT4, RD_END,
		WR_CMD, WR_DATA,
		DS_NOOP1, DS_NOOP2, DS_CMD_HDR, DS_CMD, DS_NOOP3, DS_NOOP4,
		END
	} seq_state_t;

	// Captured bus request
	typedef struct packed {
		logic      we;
		cfg_addr_t addr;
		cfg_word_t data;
	} cfg_req_t;

	// Port pin values, word still in bus bit order
	typedef struct packed {
		logic      cs_n;
		logic      rdwrn;
		cfg_word_t word;
	} cfg_drive_t;

endpackage

// ==== verilog/wb_icap_front.sv ====
// Bus side of the configuration port slave
// Registered stall, request hand-off to the sequencer,
// outstanding-request tracking, ack and read data return

`timescale 1ns/1ps

module wb_icap_front (
	input  logic                 i_clk,
	input  logic                 i_arst_n,
	// Bus
	input  logic                 i_wb_cyc,
	input  logic                 i_wb_stb,
	input  logic                 i_wb_we,
	input  icap_pkg::cfg_addr_t  i_wb_addr,
	input  icap_pkg::cfg_word_t  i_wb_data,
	output logic                 o_wb_stall,
	output logic                 o_wb_ack,
	output icap_pkg::cfg_word_t  o_wb_data,
	// Divider and sequencer
	input  logic                 i_ready,
	input  logic                 i_seq_idle,
	input  logic                 i_done,
	input  icap_pkg::cfg_word_t  i_rd_word,
	output logic                 o_req_valid,
	output icap_pkg::cfg_req_t   o_req
);

	// Accepted request still waiting for its ack
	logic pending;

	// Accept strobe, lines up with a step in IDLE
	assign o_req_valid = i_wb_stb && !o_wb_stall;
	assign o_req = '{we: i_wb_we, addr: i_wb_addr, data: i_wb_data};

	////////////////////
	// Stall
	////////////////////

	// Ready leads step by one cycle
	// so stall opens only in the step cycle
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_wb_stall <= 1'b1;
		end else begin
			o_wb_stall <= !(i_seq_idle && i_ready);
		end
	end

	////////////////////
	// Outstanding flag and ack
	////////////////////

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			pending  <= 1'b0;
			o_wb_ack <= 1'b0;
		end else begin
			// Abandoned cycle loses its ack
			o_wb_ack <= i_done && pending && i_wb_cyc;
			if (o_req_valid) begin
				pending <= 1'b1;
			end else if (i_done) begin
				pending <= 1'b0;
			end else begin
				pending <= pending && i_wb_cyc;
			end
		end
	end

	// Read word, valid alongside ack
	always_ff @(posedge i_clk) begin
		if (i_done) begin
			o_wb_data <= i_rd_word;
		end
	end

	// Done arrives once per request, never back to back
	a_ack_single: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_wb_ack |=> !o_wb_ack);

endmodule

// ==== verilog/icap_sequencer.sv ====
// Configuration port word sequencer
// Walks sync, register read or write, then desync,
// one state per slow-clock step, and flags completion

`timescale 1ns/1ps

module icap_sequencer (
	input  logic                 i_clk,
	input  logic                 i_arst_n,
	input  logic                 i_step,
	input  logic                 i_req_valid,
	input  icap_pkg::cfg_req_t   i_req,
	output logic                 o_idle,
	output logic                 o_done,
	output icap_pkg::cfg_drive_t o_drive
);

	icap_pkg::seq_state_t state;
	icap_pkg::cfg_req_t   req_q;

	// Type 1 header, one word to the given register
	function automatic icap_pkg::cfg_word_t hdr_word(
		input logic [7:0]          opcode,
		input icap_pkg::cfg_addr_t addr
	);
		return {opcode, 6'h00, addr, 13'h0001};
	endfunction

	assign o_idle = (state == icap_pkg::IDLE);

	// Read completes at RD_END, write at END
	assign o_done = i_step && ((state == icap_pkg::RD_END) ||
		((state == icap_pkg::END) && req_q.we));

	// Request held for the whole sequence
	always_ff @(posedge i_clk) begin
		if (i_req_valid) begin
			req_q <= i_req;
		end
	end

	////////////////////
	// State and port drive
	////////////////////

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state         <= icap_pkg::IDLE;
			o_drive.cs_n  <= 1'b1;
			o_drive.rdwrn <= 1'b1;
			o_drive.word  <= icap_pkg::DUMMY_WORD;
		end else if (i_step) begin
			// Most states: next state, selected, NOOP
			state        <= icap_pkg::seq_state_t'(state + 5'd1);
			o_drive.cs_n <= 1'b0;
			o_drive.word <= icap_pkg::NOOP_WORD;
			case (state)
				icap_pkg::IDLE: begin
					o_drive.cs_n  <= 1'b1;
					o_drive.rdwrn <= 1'b1;
					o_drive.word  <= icap_pkg::DUMMY_WORD;
					state <= i_req_valid ? icap_pkg::START : icap_pkg::IDLE;
				end
				icap_pkg::START: begin
					// Dummy word, port still deselected
					o_drive.cs_n <= 1'b1;
					o_drive.word <= icap_pkg::DUMMY_WORD;
				end
				icap_pkg::ACTIVATE: begin
					o_drive.rdwrn <= 1'b0;
				end
				icap_pkg::SYNC: begin
					o_drive.word <= icap_pkg::SYNC_WORD;
				end
				icap_pkg::SYNC_NOOP2: begin
					// End of sync, pick read or write
					state <= req_q.we ? icap_pkg::WR_CMD : icap_pkg::RD_CMD;
				end
				icap_pkg::RD_CMD: begin
					o_drive.word <= hdr_word(icap_pkg::RD_OPCODE, req_q.addr);
				end
				icap_pkg::RD_IDLE: begin
					// Deselect to turn the bus around
					o_drive.cs_n  <= 1'b1;
					o_drive.rdwrn <= 1'b1;
				end
				icap_pkg::RD_WAIT1: begin
					o_drive.rdwrn <= 1'b1;
				end
				icap_pkg::RD_END: begin
					// Read word is on the port now
					o_drive.cs_n  <= 1'b1;
					o_drive.rdwrn <= 1'b1;
					state         <= icap_pkg::DS_NOOP1;
				end
				icap_pkg::WR_CMD: begin
					o_drive.word <= hdr_word(icap_pkg::WR_OPCODE, req_q.addr);
				end
				icap_pkg::WR_DATA: begin
					o_drive.word <= req_q.data;
					state        <= icap_pkg::DS_NOOP1;
				end
				icap_pkg::DS_NOOP1: begin
					// Back to writing for the desync
					o_drive.rdwrn <= 1'b0;
				end
				icap_pkg::DS_CMD_HDR: begin
					o_drive.word <= icap_pkg::CMD_REG_WRITE_WORD;
				end
				icap_pkg::DS_CMD: begin
					o_drive.word <= icap_pkg::DESYNC_CMD_WORD;
				end
				icap_pkg::SYNC_NOOP1, icap_pkg::RD_NOOP1, icap_pkg::RD_NOOP2,
				icap_pkg::RD_WAIT2, icap_pkg::RD_WAIT3, icap_pkg::RD_WAIT4,
				icap_pkg::DS_NOOP2, icap_pkg::DS_NOOP3, icap_pkg::DS_NOOP4: begin
					// Plain NOOP steps
				end
				default: begin
					// END and unused codes
					o_drive.cs_n  <= 1'b1;
					o_drive.rdwrn <= 1'b0;
					o_drive.word  <= icap_pkg::DUMMY_WORD;
					state         <= icap_pkg::IDLE;
				end
			endcase
		end
	end

	// Front stall only opens on a step while idle
	a_req_in_idle: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_req_valid |-> (i_step && state == icap_pkg::IDLE));

endmodule

// ==== verilog/icap_port.sv ====
// Configuration port pin side
// Free-running divider for the slow port clock with step and
// ready strobes, and per-byte bit reversal of both data paths

`timescale 1ns/1ps

module icap_port (
	input  logic                 i_clk,
	input  logic                 i_arst_n,
	input  icap_pkg::cfg_drive_t i_drive,
	input  icap_pkg::cfg_word_t  i_cfg_data,
	output logic                 o_step,
	output logic                 o_ready,
	output icap_pkg::cfg_word_t  o_rd_word,
	output logic                 o_cfg_clk,
	output logic                 o_cfg_cs_n,
	output logic                 o_cfg_rdwrn,
	output icap_pkg::cfg_word_t  o_cfg_data
);

	logic [icap_pkg::LGDIV-1:0] div_cnt;

	// Port data is bit reversed within each byte
	function automatic icap_pkg::cfg_word_t swap_bits(input icap_pkg::cfg_word_t w);
		icap_pkg::cfg_word_t r;
		for (int b = 0; b < 4; b++) begin
			for (int k = 0; k < 8; k++) begin
				r[8*b + k] = w[8*b + 7 - k];
			end
		end
		return r;
	endfunction

	////////////////////
	// Slow clock
	////////////////////

	// Step in the last count, sequencer updates on its wrap
	// and the port samples half a slow period later
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			div_cnt <= '0;
			o_step  <= 1'b0;
			o_ready <= 1'b0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			o_step  <= (div_cnt == icap_pkg::STEP_SET_CNT);
			o_ready <= (div_cnt == icap_pkg::READY_SET_CNT);
		end
	end

	assign o_cfg_clk = div_cnt[icap_pkg::LGDIV-1];

	// Pins
	assign o_cfg_cs_n  = i_drive.cs_n;
	assign o_cfg_rdwrn = i_drive.rdwrn;
	assign o_cfg_data  = swap_bits(i_drive.word);
	assign o_rd_word   = swap_bits(i_cfg_data);

	// Ready is one cycle ahead of step, never with it
	a_step_ready_apart: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		!(o_step && o_ready));

endmodule

// ==== verilog/wb_icap_top.sv ====
// Configuration port bus slave, top level
// Bus front, word sequencer and port divider/bit reversal

`timescale 1ns/1ps

module wb_icap_top (
	input  logic                i_clk,
	input  logic                i_arst_n,
	// Bus
	input  logic                i_wb_cyc,
	input  logic                i_wb_stb,
	input  logic                i_wb_we,
	input  icap_pkg::cfg_addr_t i_wb_addr,
	input  icap_pkg::cfg_word_t i_wb_data,
	output logic                o_wb_stall,
	output logic                o_wb_ack,
	output icap_pkg::cfg_word_t o_wb_data,
	// Configuration port pins
	output logic                o_cfg_clk,
	output logic                o_cfg_cs_n,
	output logic                o_cfg_rdwrn,
	output icap_pkg::cfg_word_t o_cfg_data,
	input  icap_pkg::cfg_word_t i_cfg_data
);

	logic                 step;
	logic                 ready;
	logic                 seq_idle;
	logic                 done;
	logic                 req_valid;
	icap_pkg::cfg_req_t   req;
	icap_pkg::cfg_drive_t drive;
	icap_pkg::cfg_word_t  rd_word;

	wb_icap_front u_front (
		.i_clk       (i_clk),
		.i_arst_n    (i_arst_n),
		.i_wb_cyc    (i_wb_cyc),
		.i_wb_stb    (i_wb_stb),
		.i_wb_we     (i_wb_we),
		.i_wb_addr   (i_wb_addr),
		.i_wb_data   (i_wb_data),
		.o_wb_stall  (o_wb_stall),
		.o_wb_ack    (o_wb_ack),
		.o_wb_data   (o_wb_data),
		.i_ready     (ready),
		.i_seq_idle  (seq_idle),
		.i_done      (done),
		.i_rd_word   (rd_word),
		.o_req_valid (req_valid),
		.o_req       (req)
	);

	icap_sequencer u_seq (
		.i_clk       (i_clk),
		.i_arst_n    (i_arst_n),
		.i_step      (step),
		.i_req_valid (req_valid),
		.i_req       (req),
		.o_idle      (seq_idle),
		.o_done      (done),
		.o_drive     (drive)
	);

	icap_port u_port (
		.i_clk       (i_clk),
		.i_arst_n    (i_arst_n),
		.i_drive     (drive),
		.i_cfg_data  (i_cfg_data),
		.o_step      (step),
		.o_ready     (ready),
		.o_rd_word   (rd_word),
		.o_cfg_clk   (o_cfg_clk),
		.o_cfg_cs_n  (o_cfg_cs_n),
		.o_cfg_rdwrn (o_cfg_rdwrn),
		.o_cfg_data  (o_cfg_data)
	);

endmodule

// ==== test/tb_clock.sv ====
// Testbench clock and reset
// 20 ns clock, reset held low for the first two cycles

`timescale 1ns/1ps

module tb_clock (
	output logic o_clk,
	output logic o_arst_n
);

	initial begin
		o_clk = 1'b0;
		forever #10 o_clk = ~o_clk;
	end

	// Release on a rising edge, flops still see reset there
	initial begin
		o_arst_n = 1'b0;
		repeat (2) @(posedge o_clk);
		o_arst_n <= 1'b1;
	end

endmodule

// ==== test/tb_wb_icap.sv ====
// Testbench for the configuration port bus slave
// Bus driver from a vector file, configuration port model
// with a register shadow, stream, ack and stall checks

`timescale 1ns/1ps

module tb_wb_icap;

	localparam int MAX_VEC = 64;
	// Cycles from the accepting edge, 8 cycles per slow step
	localparam int ACK_LAT = 112;
	localparam int WR_FREE = 119;
	localparam int RD_FREE = 175;

	logic clk;
	logic arst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic wb_stall;
	logic wb_ack;
	logic cfg_clk;
	logic cfg_cs_n;
	logic cfg_rdwrn;
	icap_pkg::cfg_addr_t wb_addr;
	icap_pkg::cfg_word_t wb_data;
	icap_pkg::cfg_word_t wb_rdata;
	icap_pkg::cfg_word_t cfg_dout;
	icap_pkg::cfg_word_t cfg_din;

	// Op digit, address byte, data word
	logic [43:0] vec_mem [MAX_VEC];
	int n_vec;
	int timeout_limit = 0;
	int edge_cnt = 0;
	logic [31:0] lfsr;

	// Port model state
	icap_pkg::cfg_word_t shadow [32];
	icap_pkg::cfg_word_t stream_q [$];
	icap_pkg::cfg_word_t exp_q [$];
	int rd_cycles;
	logic wr_hdr_seen;
	icap_pkg::cfg_addr_t wr_addr;

	// Vector under way, and the one the monitor tracks
	logic [3:0] cur_op;
	icap_pkg::cfg_addr_t cur_addr;
	icap_pkg::cfg_word_t cur_data;
	logic busy;
	logic ack_due;
	logic ack_seen;
	int acc_edge;
	logic [3:0] mon_op;
	icap_pkg::cfg_addr_t mon_addr;
	icap_pkg::cfg_word_t mon_data;

	tb_clock u_clock (
		.o_clk    (clk),
		.o_arst_n (arst_n)
	);

	wb_icap_top UUT (
		.i_clk       (clk),
		.i_arst_n    (arst_n),
		.i_wb_cyc    (wb_cyc),
		.i_wb_stb    (wb_stb),
		.i_wb_we     (wb_we),
		.i_wb_addr   (wb_addr),
		.i_wb_data   (wb_data),
		.o_wb_stall  (wb_stall),
		.o_wb_ack    (wb_ack),
		.o_wb_data   (wb_rdata),
		.o_cfg_clk   (cfg_clk),
		.o_cfg_cs_n  (cfg_cs_n),
		.o_cfg_rdwrn (cfg_rdwrn),
		.o_cfg_data  (cfg_dout),
		.i_cfg_data  (cfg_din)
	);

	////////////////////
	// Helpers
	////////////////////

	// Mirror bits inside every byte
	function automatic icap_pkg::cfg_word_t byte_bit_reverse(input icap_pkg::cfg_word_t w);
		icap_pkg::cfg_word_t r;
		for (int i = 0; i < 32; i++) begin
			r[(i & ~7) + 7 - (i & 7)] = w[i];
		end
		return r;
	endfunction

	function automatic icap_pkg::cfg_word_t header_word(input logic [7:0] op,
		input icap_pkg::cfg_addr_t addr);
		return {op, 6'b0, addr, 13'd1};
	endfunction

	// Galois form, taps 32,22,2,1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_random(input int n, output int v);
		v = 0;
		for (int k = 0; k < n; k++) begin
			v = (v << 1) | int'(lfsr[0]);
			lfsr = lfsr_step(lfsr);
		end
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_word(input string name, input icap_pkg::cfg_word_t got,
		input icap_pkg::cfg_word_t exp);
		if (got !== exp) begin
			report_failure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
				$time, name, got, exp));
		end
	endtask

	task automatic check_addr(input string name, input icap_pkg::cfg_addr_t got,
		input icap_pkg::cfg_addr_t exp);
		if (got !== exp) begin
			report_failure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
				$time, name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			report_failure($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
				$time, name, got, exp));
		end
	endtask

	// Words the port must see with cs_n and rdwrn low
	task automatic build_expected(input logic we, input icap_pkg::cfg_addr_t addr,
		input icap_pkg::cfg_word_t data);
		exp_q.delete();
		exp_q.push_back(icap_pkg::NOOP_WORD);
		exp_q.push_back(icap_pkg::SYNC_WORD);
		exp_q.push_back(icap_pkg::NOOP_WORD);
		exp_q.push_back(icap_pkg::NOOP_WORD);
		if (we) begin
			exp_q.push_back(header_word(icap_pkg::WR_OPCODE, addr));
			exp_q.push_back(data);
		end else begin
			exp_q.push_back(header_word(icap_pkg::RD_OPCODE, addr));
			exp_q.push_back(icap_pkg::NOOP_WORD);
			exp_q.push_back(icap_pkg::NOOP_WORD);
		end
		exp_q.push_back(icap_pkg::NOOP_WORD);
		exp_q.push_back(icap_pkg::NOOP_WORD);
		exp_q.push_back(icap_pkg::CMD_REG_WRITE_WORD);
		exp_q.push_back(icap_pkg::DESYNC_CMD_WORD);
		exp_q.push_back(icap_pkg::NOOP_WORD);
		exp_q.push_back(icap_pkg::NOOP_WORD);
	endtask

	task automatic check_stream(input int exp_rd_cycles);
		if (stream_q.size() != exp_q.size()) begin
			report_failure($sformatf("port saw %0d words in the transaction, expected %0d",
				stream_q.size(), exp_q.size()));
		end
		check_addr("o_cfg_data header address", stream_q[4][17:13], mon_addr);
		for (int i = 0; i < exp_q.size(); i++) begin
			check_word($sformatf("o_cfg_data word %0d", i), stream_q[i], exp_q[i]);
		end
		if (rd_cycles != exp_rd_cycles) begin
			report_failure($sformatf("port saw %0d read cycles, expected %0d",
				rd_cycles, exp_rd_cycles));
		end
		stream_q.delete();
		rd_cycles = 0;
	endtask

	// One bus request; op 0 write, 1 read, 2 read dropped after acceptance
	task automatic run_vector(input logic [3:0] op, input icap_pkg::cfg_addr_t addr,
		input icap_pkg::cfg_word_t data);
		int hold;
		cur_op   = op;
		cur_addr = addr;
		cur_data = data;
		wb_cyc  <= 1'b1;
		wb_stb  <= 1'b1;
		wb_we   <= (op == 4'd0);
		wb_addr <= addr;
		wb_data <= (op == 4'd0) ? data : '0;
		do @(negedge clk); while (wb_stall);
		@(posedge clk);
		wb_stb <= 1'b0;
		if (op == 4'd2) begin
			take_random(4, hold);
			repeat (hold + 8) @(posedge clk);
			wb_cyc <= 1'b0;
		end else begin
			do @(negedge clk); while (!wb_ack);
			@(posedge clk);
			wb_cyc <= 1'b0;
		end
	endtask

	////////////////////
	// Configuration port model
	////////////////////

	always @(posedge cfg_clk) begin : port_model
		icap_pkg::cfg_word_t w;
		if (!cfg_cs_n) begin
			if (!cfg_rdwrn) begin
				w = byte_bit_reverse(cfg_dout);
				stream_q.push_back(w);
				if (wr_hdr_seen) begin
					shadow[wr_addr] = w;
					wr_hdr_seen = 1'b0;
				end else if (w[23:18] == 6'd0 && w[12:0] == 13'd1) begin
					if (w[31:24] == icap_pkg::WR_OPCODE) begin
						wr_hdr_seen = 1'b1;
						wr_addr = w[17:13];
					end else if (w[31:24] == icap_pkg::RD_OPCODE) begin
						cfg_din <= byte_bit_reverse(shadow[w[17:13]]);
					end
				end
			end else begin
				rd_cycles++;
			end
		end
	end

	////////////////////
	// Cycle count and timeout
	////////////////////

	always @(posedge clk) begin
		edge_cnt <= edge_cnt + 1;
		if (timeout_limit > 0 && edge_cnt > timeout_limit) begin
			report_failure($sformatf("timeout after %0d cycles, the DUT stopped responding",
				edge_cnt));
		end
	end

	// Ack, stall and stream checks, sampled mid-cycle
	always @(negedge clk) begin : monitor
		int since;
		int free_at;
		if (arst_n) begin
			if (busy) begin
				since = edge_cnt - acc_edge;
				if (wb_ack) begin
					if (!ack_due) begin
						report_failure("ack seen for a request that expects none");
					end
					if (since != ACK_LAT) begin
						report_failure($sformatf("ack came %0d cycles after acceptance, expected %0d",
							since, ACK_LAT));
					end
					if (mon_op == 4'd1) begin
						check_word("o_wb_data", wb_rdata, mon_data);
					end
					ack_due  = 1'b0;
					ack_seen = 1'b1;
				end
				free_at = (mon_op == 4'd0) ? WR_FREE : RD_FREE;
				if (since < free_at) begin
					check_bit("o_wb_stall", wb_stall, 1'b1);
				end else begin
					// Back in IDLE, stall opens on the next step
					check_bit("o_wb_stall", wb_stall, 1'b0);
					if (mon_op != 4'd2 && !ack_seen) begin
						report_failure("request finished without an ack");
					end
					build_expected(mon_op == 4'd0, mon_addr, mon_data);
					check_stream((mon_op == 4'd0) ? 0 : 4);
					busy = 1'b0;
				end
			end else if (wb_ack) begin
				report_failure("ack seen with no request outstanding");
			end
			// Accepted on the coming edge
			if (!busy && wb_cyc && wb_stb && !wb_stall) begin
				busy     = 1'b1;
				ack_due  = (cur_op != 4'd2);
				ack_seen = 1'b0;
				acc_edge = edge_cnt + 1;
				mon_op   = cur_op;
				mon_addr = cur_addr;
				mon_data = cur_data;
			end
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	initial begin : stimulus
		int gap;
		wb_cyc      = 1'b0;
		wb_stb      = 1'b0;
		wb_we       = 1'b0;
		wb_addr     = '0;
		wb_data     = '0;
		cfg_din     = '0;
		lfsr        = 32'hbcce_9634;
		busy        = 1'b0;
		ack_due     = 1'b0;
		ack_seen    = 1'b0;
		rd_cycles   = 0;
		wr_hdr_seen = 1'b0;
		wr_addr     = '0;
		cur_op      = '0;
		cur_addr    = '0;
		cur_data    = '0;
		// Unwritten registers read back their own address
		for (int i = 0; i < 32; i++) begin
			shadow[i] = 32'hC0DE_0000 | {16'h0, 3'b0, 5'(i), 3'b0, 5'(i)};
		end
		// Op digit F marks the end of the vectors
		for (int i = 0; i < MAX_VEC; i++) begin
			vec_mem[i] = '1;
		end
		$readmemh("test/icap_vectors.txt", vec_mem);
		n_vec = 0;
		while (n_vec < MAX_VEC && vec_mem[n_vec][43:40] != 4'hF) begin
			n_vec++;
		end
		if (n_vec == 0) begin
			report_failure("no vectors found in test/icap_vectors.txt");
		end
		timeout_limit = n_vec * 200 + n_vec * (16 + 24) + 16;

		@(posedge arst_n);
		@(negedge clk);
		check_bit("o_wb_stall", wb_stall, 1'b1);
		check_bit("o_wb_ack", wb_ack, 1'b0);
		check_bit("o_cfg_cs_n", cfg_cs_n, 1'b1);
		check_bit("o_cfg_rdwrn", cfg_rdwrn, 1'b1);

		for (int i = 0; i < n_vec; i++) begin
			take_random(4, gap);
			repeat (gap + 1) @(posedge clk);
			run_vector(vec_mem[i][43:40], vec_mem[i][36:32], vec_mem[i][31:0]);
		end
		// Let the last sequence run out
		do @(negedge clk); while (busy);
		$display("Finished with no errors");
		$finish;
	end

endmodule

// ==== sources.f ====
verilog/icap_pkg.sv
verilog/wb_icap_front.sv
verilog/icap_sequencer.sv
verilog/icap_port.sv
verilog/wb_icap_top.sv
test/tb_clock.sv
test/tb_wb_icap.sv

// ==== Makefile ====
# Verilator build and run for the configuration port bus slave

VERILATOR ?= verilator
TOP       ?= tb_wb_icap
FLIST     ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Finished with no errors

SRCS    := $(shell grep -v '^+' $(FLIST))
VECTORS := test/icap_vectors.txt
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

$(LOG): $(BIN) $(VECTORS)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)

run: $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

check:
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/icap_vectors.txt ====
// op digit (0 write, 1 read, 2 read dropped after acceptance),
// address 2 hex digits, data or expected read value 8 hex digits
00312345678
10312345678
01FA5C30F81
11FA5C30F81
107C0DE0707
00000000001
20300000000
10000000001
003CAFEF00D
21F00000000
103CAFEF00D
11FA5C30F81
01080000001
11080000001
